// ==== source/memPkg.sv ====
package memPkg;

    typedef logic [31:0] addr_t;
    typedef logic [31:0] word_t;
    typedef logic [7:0]  byte_t;

    // byte count minus one: 0, 1 or 3
    typedef logic [1:0] accLen_t;

    typedef enum logic [1:0] {
        OWN_FREE,
        OWN_DATA,
        OWN_FETCH
    } memOwner_t;

    typedef enum logic [1:0] {
        ARB_IDLE,
        ARB_FETCH,
        ARB_LOAD,
        ARB_STORE
    } arbState_t;

    typedef struct packed {
        logic    isStore;
        logic    isSigned;
        accLen_t len;
        addr_t   addr;
        word_t   wdata;
    } dataReq_t;

    typedef struct packed {
        logic  en;
        logic  we;
        addr_t addr;
        byte_t wdata;
    } memPort_t;

endpackage

// ==== source/byteRam.sv ====
`timescale 1ns/1ps

module byteRam import memPkg::*; #(
    parameter int RAM_ADDR_BITS = 12
) (
    input  logic     clk,
    input  memPort_t i_port,
    output byte_t    o_rdata
);

    byte_t mem [2**RAM_ADDR_BITS];
    logic [RAM_ADDR_BITS-1:0] index;

    // upper address bits are ignored
    assign index = i_port.addr[RAM_ADDR_BITS-1:0];

    always_ff @(posedge clk) begin
        if (i_port.en && i_port.we) begin
            mem[index] <= i_port.wdata;
        end
    end

    // read data holds while en is low
    always_ff @(posedge clk) begin
        if (i_port.en && !i_port.we) begin
            o_rdata <= mem[index];
        end
    end

endmodule

// ==== source/memArbiter.sv ====
`timescale 1ns/1ps

module memArbiter import memPkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      i_rdy,
    input  logic      i_ioBufferFull,

    input  logic      i_fetchReq,
    input  addr_t     i_fetchAddr,
    output logic      o_fetchDone,
    output word_t     o_fetchInst,

    input  logic      i_dataReq,
    input  dataReq_t  i_dataCmd,
    output logic      o_dataDone,
    output word_t     o_dataRdata,

    output memPort_t  o_memPort,
    input  byte_t     i_memRdata,

    output memOwner_t o_memOwner
);

    arbState_t state;
    logic [2:0] byteCnt;
    logic [2:0] cntEnd;
    accLen_t reqLen;
    addr_t curAddr;
    word_t storeWord;
    word_t asmWord;
    word_t doneWord;
    logic paused;
    logic active;
    logic lastCycle;
    logic issue;
    logic done;

    assign paused    = !i_rdy || i_ioBufferFull;
    assign active    = (state != ARB_IDLE);
    assign cntEnd    = {1'b0, reqLen} + 3'd1;
    // cycle N: no RAM access, only the done pulse
    assign lastCycle = active && (byteCnt == cntEnd);
    assign issue     = active && !lastCycle && !paused;
    assign done      = lastCycle && !paused;

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= ARB_IDLE;
            byteCnt <= '0;
        end else if (!paused) begin
            case (state)
                ARB_IDLE: begin
                    byteCnt <= '0;
                    // data wins over fetch
                    if (i_dataReq) begin
                        state <= i_dataCmd.isStore ? ARB_STORE : ARB_LOAD;
                    end else if (i_fetchReq) begin
                        state <= ARB_FETCH;
                    end
                end
                default: begin
                    if (lastCycle) begin
                        state <= ARB_IDLE;
                    end else begin
                        byteCnt <= byteCnt + 3'd1;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!paused) begin
            if (state == ARB_IDLE) begin
                asmWord <= '0;
                if (i_dataReq) begin
                    curAddr   <= i_dataCmd.addr;
                    reqLen    <= i_dataCmd.len;
                    storeWord <= i_dataCmd.wdata;
                end else begin
                    curAddr <= i_fetchAddr;
                    reqLen  <= 2'd3;
                end
            end else begin
                if (issue) begin
                    curAddr <= curAddr + 32'd1;
                end
                // byte k-1 arrives in cycle k
                if (state != ARB_STORE && byteCnt != 3'd0 && !lastCycle) begin
                    asmWord[{byteCnt[1:0] - 2'd1, 3'b000} +: 8] <= i_memRdata;
                end
            end
        end
    end

    // last byte goes straight from the RAM into the result
    always_comb begin
        doneWord = asmWord;
        doneWord[{reqLen, 3'b000} +: 8] = i_memRdata;
    end

    always_comb begin
        o_memPort.en    = issue;
        o_memPort.we    = issue && (state == ARB_STORE);
        o_memPort.addr  = curAddr;
        o_memPort.wdata = storeWord[{byteCnt[1:0], 3'b000} +: 8];
    end

    assign o_fetchDone = done && (state == ARB_FETCH);
    assign o_fetchInst = doneWord;
    assign o_dataDone  = done && (state == ARB_LOAD || state == ARB_STORE);
    assign o_dataRdata = doneWord;

    always_comb begin
        case (state)
            ARB_FETCH: o_memOwner = OWN_FETCH;
            ARB_LOAD:  o_memOwner = OWN_DATA;
            ARB_STORE: o_memOwner = OWN_DATA;
            default:   o_memOwner = OWN_FREE;
        endcase
    end

endmodule

// ==== source/instFetch.sv ====
`timescale 1ns/1ps

module instFetch import memPkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  logic  i_redirect,
    input  addr_t i_redirectPc,
    input  logic  i_instTake,
    output logic  o_fetchReq,
    output addr_t o_fetchAddr,
    input  logic  i_fetchDone,
    input  word_t i_fetchInst,
    output logic  o_instValid,
    output word_t o_inst,
    output addr_t o_instPc
);

    addr_t pc;
    logic slotValid;
    logic dropNext;
    word_t slotInst;
    addr_t slotPc;

    // keep asking as long as the slot is empty
    assign o_fetchReq  = !slotValid;
    assign o_fetchAddr = pc;
    assign o_instValid = slotValid;
    assign o_inst      = slotInst;
    assign o_instPc    = slotPc;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc        <= '0;
            slotValid <= 1'b0;
            dropNext  <= 1'b0;
        end else if (i_redirect) begin
            pc        <= i_redirectPc;
            slotValid <= 1'b0;
            // an accepted fetch for the old pc may still come back
            dropNext  <= o_fetchReq && !i_fetchDone;
        end else if (i_fetchDone) begin
            if (dropNext) begin
                dropNext <= 1'b0;
            end else begin
                slotValid <= 1'b1;
                pc        <= pc + 32'd4;
            end
        end else if (i_instTake) begin
            slotValid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (i_fetchDone && !dropNext && !i_redirect) begin
            slotInst <= i_fetchInst;
            slotPc   <= pc;
        end
    end

endmodule

// ==== source/dataAccess.sv ====
`timescale 1ns/1ps

module dataAccess import memPkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     i_dataReq,
    input  dataReq_t i_dataCmd,
    output logic     o_dataBusy,
    output logic     o_loadDone,
    output word_t    o_loadData,
    output logic     o_storeDone,
    output logic     o_arbReq,
    output dataReq_t o_arbCmd,
    input  logic     i_arbDone,
    input  word_t    i_arbRdata
);

    logic busy;
    dataReq_t cmd;
    logic loadDone;
    logic storeDone;
    word_t loadData;
    word_t extData;

    // arbiter returns zero-extended data
    always_comb begin
        case (cmd.len)
            2'd0: extData = cmd.isSigned ? {{24{i_arbRdata[7]}}, i_arbRdata[7:0]} : i_arbRdata;
            2'd1: extData = cmd.isSigned ? {{16{i_arbRdata[15]}}, i_arbRdata[15:0]} : i_arbRdata;
            default: extData = i_arbRdata;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            busy      <= 1'b0;
            loadDone  <= 1'b0;
            storeDone <= 1'b0;
        end else begin
            loadDone  <= i_arbDone && !cmd.isStore;
            storeDone <= i_arbDone && cmd.isStore;
            if (i_arbDone) begin
                busy <= 1'b0;
            end else if (!busy && i_dataReq) begin
                busy <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!busy && i_dataReq) begin
            cmd <= i_dataCmd;
        end
        if (i_arbDone) begin
            loadData <= extData;
        end
    end

    assign o_dataBusy  = busy;
    assign o_arbReq    = busy;
    assign o_arbCmd    = cmd;
    assign o_loadDone  = loadDone;
    assign o_storeDone = storeDone;
    assign o_loadData  = loadData;

endmodule

// ==== source/memSubsystem.sv ====
`timescale 1ns/1ps

module memSubsystem import memPkg::*; #(
    parameter int RAM_ADDR_BITS = 12
) (
    input  logic      clk,
    input  logic      rst,
    input  logic      i_rdy,
    input  logic      i_ioBufferFull,
    input  logic      i_dataReq,
    input  dataReq_t  i_dataCmd,
    output logic      o_dataBusy,
    output logic      o_loadDone,
    output word_t     o_loadData,
    output logic      o_storeDone,
    input  logic      i_redirect,
    input  addr_t     i_redirectPc,
    input  logic      i_instTake,
    output logic      o_instValid,
    output word_t     o_inst,
    output addr_t     o_instPc,
    output memOwner_t o_memOwner
);

    logic fetchReq;
    addr_t fetchAddr;
    logic fetchDone;
    word_t fetchInst;
    logic arbReq;
    dataReq_t arbCmd;
    logic arbDone;
    word_t arbRdata;
    memPort_t memPort;
    byte_t memRdata;

    instFetch instFetch_inst (
        .clk(clk),
        .rst(rst),
        .i_redirect(i_redirect),
        .i_redirectPc(i_redirectPc),
        .i_instTake(i_instTake),
        .o_fetchReq(fetchReq),
        .o_fetchAddr(fetchAddr),
        .i_fetchDone(fetchDone),
        .i_fetchInst(fetchInst),
        .o_instValid(o_instValid),
        .o_inst(o_inst),
        .o_instPc(o_instPc)
    );

    dataAccess dataAccess_inst (
        .clk(clk),
        .rst(rst),
        .i_dataReq(i_dataReq),
        .i_dataCmd(i_dataCmd),
        .o_dataBusy(o_dataBusy),
        .o_loadDone(o_loadDone),
        .o_loadData(o_loadData),
        .o_storeDone(o_storeDone),
        .o_arbReq(arbReq),
        .o_arbCmd(arbCmd),
        .i_arbDone(arbDone),
        .i_arbRdata(arbRdata)
    );

    memArbiter memArbiter_inst (
        .clk(clk),
        .rst(rst),
        .i_rdy(i_rdy),
        .i_ioBufferFull(i_ioBufferFull),
        .i_fetchReq(fetchReq),
        .i_fetchAddr(fetchAddr),
        .o_fetchDone(fetchDone),
        .o_fetchInst(fetchInst),
        .i_dataReq(arbReq),
        .i_dataCmd(arbCmd),
        .o_dataDone(arbDone),
        .o_dataRdata(arbRdata),
        .o_memPort(memPort),
        .i_memRdata(memRdata),
        .o_memOwner(o_memOwner)
    );

    byteRam #(
        .RAM_ADDR_BITS(RAM_ADDR_BITS)
    ) byteRam_inst (
        .clk(clk),
        .i_port(memPort),
        .o_rdata(memRdata)
    );

endmodule

// ==== verification/memSubsystem_checker.sv ====
`timescale 1ns/1ps

module memSubsystem_checker import memPkg::*; (
    input logic      clk,
    input logic      rst,
    input logic      i_rdy,
    input logic      i_ioBufferFull,
    input logic      i_fetchDone,
    input logic      i_dataDone,
    input memPort_t  i_memPort,
    input memOwner_t i_memOwner
);

    logic paused;

    assign paused = !i_rdy || i_ioBufferFull;

    // one client completes per cycle
    assert property (@(posedge clk) disable iff (rst) !(i_fetchDone && i_dataDone))
        else $error("fetch and data done pulses in the same cycle");

    assert property (@(posedge clk) disable iff (rst) paused |-> !i_memPort.en && !i_memPort.we)
        else $error("RAM enabled while the arbiter is paused");

    assert property (@(posedge clk) disable iff (rst) paused |-> !i_fetchDone && !i_dataDone)
        else $error("done pulse while the arbiter is paused");

    // arbiter is idle in the cycle after a done
    assert property (@(posedge clk) disable iff (rst)
        (i_fetchDone || i_dataDone) |=> (i_memOwner == OWN_FREE))
        else $error("owner not free after a completed access");

endmodule

bind memArbiter memSubsystem_checker memSubsystem_checker_inst (
    .clk(clk),
    .rst(rst),
    .i_rdy(i_rdy),
    .i_ioBufferFull(i_ioBufferFull),
    .i_fetchDone(o_fetchDone),
    .i_dataDone(o_dataDone),
    .i_memPort(o_memPort),
    .i_memOwner(o_memOwner)
);

// ==== verification/memSubsystem_tb.sv ====
`timescale 1ns/1ps

module memSubsystem_tb import memPkg::*; ();

    localparam int RAM_BITS = 12;
    localparam int TIMEOUT = 400;
    localparam addr_t PROG_A = 32'h0000_0800;
    localparam addr_t PROG_B = 32'h0000_0900;

    logic clk;
    logic rst;
    logic i_rdy;
    logic i_ioBufferFull;
    logic i_dataReq;
    dataReq_t i_dataCmd;
    logic o_dataBusy;
    logic o_loadDone;
    word_t o_loadData;
    logic o_storeDone;
    logic i_redirect;
    addr_t i_redirectPc;
    logic i_instTake;
    logic o_instValid;
    word_t o_inst;
    addr_t o_instPc;
    memOwner_t o_memOwner;

    // mirror of every completed store
    byte_t model [2**RAM_BITS];
    logic [31:0] rngState;
    logic pauseMode;
    int checks;
    int errors;

    memSubsystem #(
        .RAM_ADDR_BITS(RAM_BITS)
    ) memSubsystem_inst (
        .clk(clk),
        .rst(rst),
        .i_rdy(i_rdy),
        .i_ioBufferFull(i_ioBufferFull),
        .i_dataReq(i_dataReq),
        .i_dataCmd(i_dataCmd),
        .o_dataBusy(o_dataBusy),
        .o_loadDone(o_loadDone),
        .o_loadData(o_loadData),
        .o_storeDone(o_storeDone),
        .i_redirect(i_redirect),
        .i_redirectPc(i_redirectPc),
        .i_instTake(i_instTake),
        .o_instValid(o_instValid),
        .o_inst(o_inst),
        .o_instPc(o_instPc),
        .o_memOwner(o_memOwner)
    );

    always #10 clk = ~clk;

    function automatic logic [31:0] nextRand();
        rngState = rngState * 32'd1664525 + 32'd1013904223;
        return rngState;
    endfunction

    // one cycle, with random stalls when pausing is on
    task automatic tick();
        logic [31:0] r;
        @(negedge clk);
        if (pauseMode) begin
            r = nextRand();
            i_rdy = (r[7:5] != 3'd0);
            i_ioBufferFull = (r[12:10] == 3'd0);
        end
    endtask

    task automatic checkWord(input string name, input word_t got, input word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED at %0t: %s is %08h, expected %08h", $time, name, got, exp);
        end
    endtask

    task automatic checkAddr(input string name, input addr_t got, input addr_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED at %0t: %s is %08h, expected %08h", $time, name, got, exp);
        end
    endtask

    function automatic dataReq_t makeCmd(input logic isStore, input logic isSigned,
                                         input accLen_t len, input addr_t addr,
                                         input word_t wdata);
        dataReq_t c;
        c.isStore = isStore;
        c.isSigned = isSigned;
        c.len = len;
        c.addr = addr;
        c.wdata = wdata;
        return c;
    endfunction

    // little-endian bytes from the model, then extension
    function automatic word_t modelRead(input addr_t addr, input accLen_t len,
                                        input logic isSigned);
        word_t w;
        addr_t a;
        int k;
        w = '0;
        for (k = 0; k <= int'(len); k++) begin
            a = addr + addr_t'(k);
            w[8*k +: 8] = model[a[RAM_BITS-1:0]];
        end
        if (isSigned && len == 2'd0) begin
            w = {{24{w[7]}}, w[7:0]};
        end else if (isSigned && len == 2'd1) begin
            w = {{16{w[15]}}, w[15:0]};
        end
        return w;
    endfunction

    task automatic modelWrite(input accLen_t len, input addr_t addr, input word_t wdata);
        addr_t a;
        int k;
        for (k = 0; k <= int'(len); k++) begin
            a = addr + addr_t'(k);
            model[a[RAM_BITS-1:0]] = wdata[8*k +: 8];
        end
    endtask

    task automatic sendData(input dataReq_t cmd);
        int t;
        t = 0;
        while (o_dataBusy && t < TIMEOUT) begin
            tick();
            t++;
        end
        if (o_dataBusy) begin
            errors++;
            $display("timeout at %0t: data unit stayed busy", $time);
        end
        i_dataCmd = cmd;
        i_dataReq = 1'b1;
        tick();
        i_dataReq = 1'b0;
    endtask

    task automatic waitData(input logic isStore, output word_t data);
        int t;
        t = 0;
        while (!(isStore ? o_storeDone : o_loadDone) && t < TIMEOUT) begin
            tick();
            t++;
        end
        if (!(isStore ? o_storeDone : o_loadDone)) begin
            errors++;
            $display("timeout at %0t: no completion pulse from the data unit", $time);
        end
        data = o_loadData;
    endtask

    task automatic doStore(input accLen_t len, input addr_t addr, input word_t wdata);
        word_t unused;
        sendData(makeCmd(1'b1, 1'b0, len, addr, wdata));
        waitData(1'b1, unused);
        modelWrite(len, addr, wdata);
    endtask

    task automatic doLoad(input logic isSigned, input accLen_t len, input addr_t addr);
        word_t data;
        sendData(makeCmd(1'b0, isSigned, len, addr, '0));
        waitData(1'b0, data);
        checkWord("o_loadData", data, modelRead(addr, len, isSigned));
    endtask

    task automatic redirectTo(input addr_t pc);
        i_redirect = 1'b1;
        i_redirectPc = pc;
        tick();
        i_redirect = 1'b0;
    endtask

    task automatic waitOwner(input memOwner_t owner);
        int t;
        t = 0;
        while (o_memOwner != owner && t < TIMEOUT) begin
            tick();
            t++;
        end
        if (o_memOwner != owner) begin
            errors++;
            $display("timeout at %0t: memory owner never became %s", $time, owner.name());
        end
    endtask

    task automatic takeInst(input addr_t expPc);
        int t;
        t = 0;
        while (!o_instValid && t < TIMEOUT) begin
            tick();
            t++;
        end
        if (!o_instValid) begin
            errors++;
            $display("timeout at %0t: no instruction for pc %08h", $time, expPc);
        end else begin
            checkAddr("o_instPc", o_instPc, expPc);
            checkWord("o_inst", o_inst, modelRead(expPc, 2'd3, 1'b0));
            i_instTake = 1'b1;
            tick();
            i_instTake = 1'b0;
        end
    endtask

    task automatic randomAccessTest();
        addr_t addrs [12];
        accLen_t lens [12];
        logic [31:0] r;
        int i;
        for (i = 0; i < 12; i++) begin
            r = nextRand();
            addrs[i] = {22'h0, r[9:0]};
            lens[i] = (r[11:10] == 2'd2) ? 2'd3 : r[11:10];
            doStore(lens[i], addrs[i], nextRand());
        end
        for (i = 0; i < 12; i++) begin
            doLoad(1'b0, lens[i], addrs[i]);
        end
    endtask

    task automatic signedLoadTest();
        logic [31:0] r;
        addr_t a;
        int i;
        for (i = 0; i < 4; i++) begin
            r = nextRand();
            a = {22'h0, r[9:0]};
            doStore(2'd0, a, {24'h0, 1'b1, r[22:16]});
            doLoad(1'b1, 2'd0, a);
            r = nextRand();
            a = {22'h0, r[9:0]};
            doStore(2'd1, a, {16'h0, 1'b1, r[30:16]});
            doLoad(1'b1, 2'd1, a);
        end
    endtask

    task automatic fetchOrderTest();
        int i;
        for (i = 0; i < 4; i++) begin
            doStore(2'd3, PROG_A + addr_t'(4 * i), nextRand());
            doStore(2'd3, PROG_B + addr_t'(4 * i), nextRand());
        end
        redirectTo(PROG_A);
        for (i = 0; i < 4; i++) begin
            takeInst(PROG_A + addr_t'(4 * i));
        end
    endtask

    // load and refetch compete when the fetch in flight ends
    task automatic dataPriorityTest();
        logic leftFetch;
        logic sawData;
        int t;
        int i;
        redirectTo(PROG_A);
        waitOwner(OWN_FETCH);
        i_dataCmd = makeCmd(1'b0, 1'b0, 2'd3, PROG_A + 32'd8, '0);
        i_dataReq = 1'b1;
        i_redirect = 1'b1;
        i_redirectPc = PROG_A;
        tick();
        i_dataReq = 1'b0;
        i_redirect = 1'b0;
        leftFetch = 1'b0;
        sawData = 1'b0;
        t = 0;
        while (!o_loadDone && t < TIMEOUT) begin
            if (o_memOwner != OWN_FETCH) begin
                leftFetch = 1'b1;
            end else if (leftFetch && !sawData) begin
                errors++;
                $display("fetch got the memory before the pending load at %0t", $time);
            end
            if (o_memOwner == OWN_DATA) begin
                sawData = 1'b1;
            end
            tick();
            t++;
        end
        if (!o_loadDone) begin
            errors++;
            $display("timeout at %0t: load during fetch never completed", $time);
        end
        if (!sawData) begin
            errors++;
            $display("memory owner never showed the data unit during the load");
        end
        checkWord("o_loadData", o_loadData, modelRead(PROG_A + 32'd8, 2'd3, 1'b0));
        for (i = 0; i < 4; i++) begin
            takeInst(PROG_A + addr_t'(4 * i));
        end
    endtask

    task automatic redirectInFlightTest();
        int i;
        redirectTo(PROG_A);
        waitOwner(OWN_FETCH);
        redirectTo(PROG_B);
        for (i = 0; i < 4; i++) begin
            takeInst(PROG_B + addr_t'(4 * i));
        end
    endtask

    task automatic pausedAccessTest();
        logic [31:0] r;
        addr_t a;
        accLen_t len;
        int i;
        pauseMode = 1'b1;
        for (i = 0; i < 8; i++) begin
            r = nextRand();
            a = {22'h0, r[9:0]};
            len = (r[11:10] == 2'd2) ? 2'd3 : r[11:10];
            doStore(len, a, nextRand());
            doLoad(r[12], len, a);
        end
        redirectTo(PROG_B);
        for (i = 0; i < 4; i++) begin
            takeInst(PROG_B + addr_t'(4 * i));
        end
        pauseMode = 1'b0;
        i_rdy = 1'b1;
        i_ioBufferFull = 1'b0;
        tick();
    endtask

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        i_rdy = 1'b1;
        i_ioBufferFull = 1'b0;
        i_dataReq = 1'b0;
        i_dataCmd = '0;
        i_redirect = 1'b0;
        i_redirectPc = '0;
        i_instTake = 1'b0;
        pauseMode = 1'b0;
        rngState = 32'hffc6b7c9;
        checks = 0;
        errors = 0;
        repeat (10) @(negedge clk);
        rst = 1'b0;
        tick();

        randomAccessTest();
        signedLoadTest();
        fetchOrderTest();
        dataPriorityTest();
        redirectInFlightTest();
        pausedAccessTest();

        $display("checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// ==== verilog.f ====
source/memPkg.sv
source/byteRam.sv
source/memArbiter.sv
source/instFetch.sv
source/dataAccess.sv
source/memSubsystem.sv
verification/memSubsystem_checker.sv
verification/memSubsystem_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = memSubsystem_tb
FILELIST  = verilog.f
OBJDIR    = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	-./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qF '** FAIL **' $(LOG) || ! grep -qF '** PASS **' $(LOG); then \
		echo "simulation failed"; exit 1; \
	fi

clean:
	rm -rf $(OBJDIR) $(LOG)
